// File: blur_geom_pkg.sv
`default_nettype none

package blur_geom_pkg;

  // Image geometry with one pass per column segment
  localparam int IMG_ROWS = 16;
  localparam int IMG_COLS = 4;

  localparam int PIX_W   = 8;
  localparam int SEG_PIX = 2;
  localparam int SEG_W   = PIX_W * SEG_PIX;
  localparam int ROW_W   = SEG_W * IMG_COLS;

  // Lanes for 3x3, 5x5 (two halves) and 7x7 kernels
  localparam int N_LANES = 4;

  localparam int PRIME_CYCLES = 3;

  // Lane start steps follow the kernel heights
  localparam int LANE_START_STEP [N_LANES] = '{0, 1, 1, 2};
  localparam int MAX_START_STEP = 2;

endpackage

`default_nettype wire

// File: blur_types_pkg.sv
`default_nettype none

package blur_types_pkg;

  // Wide enough to hold IMG_ROWS as the end value of every address
  typedef logic [$clog2(blur_geom_pkg::IMG_ROWS + 1)-1:0] row_addr_t;

  typedef logic [$clog2(blur_geom_pkg::IMG_COLS)-1:0] col_idx_t;

  typedef logic [blur_geom_pkg::SEG_W-1:0] seg_t;

  typedef logic [blur_geom_pkg::ROW_W-1:0] row_word_t;

  typedef logic [$clog2(blur_geom_pkg::MAX_START_STEP + 1)-1:0] step_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PRIME,
    ST_ROWS
  } seq_state_t;

endpackage

`default_nettype wire

// File: lane_ctrl_if.sv
`default_nettype none

interface lane_ctrl_if;

  logic                      rows_active;
  logic                      addr_clear;
  blur_types_pkg::step_t     row_step;
  blur_types_pkg::col_idx_t  current_col;

  modport sequencer (
    output rows_active,
    output addr_clear,
    output row_step,
    output current_col
  );

  modport lane (
    input rows_active,
    input addr_clear,
    input row_step,
    input current_col
  );

  modport tracker (
    input addr_clear
  );

endinterface

`default_nettype wire

// File: blur_sequencer.sv
`default_nettype none

module blur_sequencer (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      start,
  input  logic                      pass_end,
  lane_ctrl_if.sequencer            ctrl,
  output blur_types_pkg::row_addr_t img_addr,
  output logic                      buffer_we,
  output logic                      fill_zero,
  output logic                      done
);

  blur_types_pkg::seq_state_t state;
  blur_types_pkg::seq_state_t state_nxt;

  logic [$clog2(blur_geom_pkg::PRIME_CYCLES)-1:0] prime_cnt;

  logic prime_last;
  logic last_col;
  logic below_end;
  logic at_end;
  logic at_end_q;

  assign prime_last = int'(prime_cnt) == blur_geom_pkg::PRIME_CYCLES - 1;
  assign last_col   = ctrl.current_col
                      == blur_types_pkg::col_idx_t'(blur_geom_pkg::IMG_COLS - 1);
  assign below_end  = img_addr < blur_types_pkg::row_addr_t'(blur_geom_pkg::IMG_ROWS);
  assign at_end     = img_addr == blur_types_pkg::row_addr_t'(blur_geom_pkg::IMG_ROWS);

  assign ctrl.rows_active = state == blur_types_pkg::ST_ROWS;
  assign ctrl.addr_clear  = state == blur_types_pkg::ST_IDLE
                            || state == blur_types_pkg::ST_PRIME;

  // SRAM data trails its address by a cycle, so priming writes start late
  assign buffer_we = (state == blur_types_pkg::ST_PRIME
                      && int'(prime_cnt) >= blur_geom_pkg::PRIME_CYCLES - 2)
                     || (state == blur_types_pkg::ST_ROWS && below_end);

  always_comb begin
    state_nxt = state;
    case (state)
      blur_types_pkg::ST_IDLE: begin
        if (start) state_nxt = blur_types_pkg::ST_PRIME;
      end
      blur_types_pkg::ST_PRIME: begin
        if (prime_last) state_nxt = blur_types_pkg::ST_ROWS;
      end
      blur_types_pkg::ST_ROWS: begin
        if (pass_end) begin
          state_nxt = last_col ? blur_types_pkg::ST_IDLE : blur_types_pkg::ST_PRIME;
        end
      end
      default: state_nxt = blur_types_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state            <= blur_types_pkg::ST_IDLE;
      prime_cnt        <= '0;
      img_addr         <= '0;
      ctrl.row_step    <= '0;
      ctrl.current_col <= '0;
      done             <= 1'b0;
    end else begin
      state <= state_nxt;
      case (state)
        blur_types_pkg::ST_IDLE: begin
          img_addr <= '0;
          if (start) begin
            done             <= 1'b0;
            ctrl.current_col <= '0;
          end
        end
        blur_types_pkg::ST_PRIME: begin
          prime_cnt <= prime_last ? '0 : prime_cnt + 1'b1;
          img_addr  <= img_addr + 1'b1;
        end
        blur_types_pkg::ST_ROWS: begin
          if (ctrl.row_step != blur_types_pkg::step_t'(blur_geom_pkg::MAX_START_STEP)) begin
            ctrl.row_step <= ctrl.row_step + 1'b1;
          end
          if (pass_end) begin
            img_addr      <= '0;
            ctrl.row_step <= '0;
            if (last_col) done <= 1'b1;
            else ctrl.current_col <= ctrl.current_col + 1'b1;
          end else if (below_end) begin
            img_addr <= img_addr + 1'b1;
          end
        end
        default: img_addr <= '0;
      endcase
    end
  end

  // One zero-fill strobe when the address first reaches the end
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      at_end_q  <= 1'b0;
      fill_zero <= 1'b0;
    end else begin
      at_end_q  <= at_end;
      fill_zero <= at_end && !at_end_q;
    end
  end

endmodule

`default_nettype wire

// File: blur_row_lane.sv
`default_nettype none

module blur_row_lane #(
  parameter int START_STEP = 0
) (
  input  logic                        clk,
  input  logic                        rst_n,
  lane_ctrl_if.lane                   ctrl,
  input  blur_types_pkg::seg_t        blur_result,
  input  blur_types_pkg::row_word_t   blur_dout,
  output blur_types_pkg::row_addr_t   blur_addr_r,
  output blur_types_pkg::row_addr_t   blur_addr_w,
  output blur_types_pkg::row_word_t   blur_din,
  output logic                        blur_mem_we,
  output logic                        lane_last_write
);

  logic                      started;
  logic                      step_hit;
  logic                      rd_en;
  logic                      rd_valid_q;
  blur_types_pkg::row_addr_t rd_addr_q;
  blur_types_pkg::row_word_t merged;

  assign step_hit = ctrl.row_step == blur_types_pkg::step_t'(START_STEP);
  assign rd_en    = ctrl.rows_active && (started || step_hit)
                    && blur_addr_r < blur_types_pkg::row_addr_t'(blur_geom_pkg::IMG_ROWS);

  // Read address holds at IMG_ROWS once the column is read out
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      started     <= 1'b0;
      blur_addr_r <= '0;
    end else if (ctrl.addr_clear) begin
      started     <= 1'b0;
      blur_addr_r <= '0;
    end else begin
      if (step_hit) started <= 1'b1;
      if (rd_en) blur_addr_r <= blur_addr_r + 1'b1;
    end
  end

  // First stage lines up with the SRAM read latency
  always_ff @(posedge clk) begin
    if (!rst_n) rd_valid_q <= 1'b0;
    else rd_valid_q <= rd_en;
  end

  always_ff @(posedge clk) begin
    if (rd_en) rd_addr_q <= blur_addr_r;
  end

  // Segment 0 sits at the top of the row
  always_comb begin
    merged = '0;
    for (int s = 0; s < blur_geom_pkg::IMG_COLS; s++) begin
      if (s < int'(ctrl.current_col)) begin
        merged[blur_geom_pkg::ROW_W - 1 - s * blur_geom_pkg::SEG_W -: blur_geom_pkg::SEG_W] =
          blur_dout[blur_geom_pkg::ROW_W - 1 - s * blur_geom_pkg::SEG_W -: blur_geom_pkg::SEG_W];
      end else if (s == int'(ctrl.current_col)) begin
        merged[blur_geom_pkg::ROW_W - 1 - s * blur_geom_pkg::SEG_W -: blur_geom_pkg::SEG_W] =
          blur_result;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      blur_mem_we     <= 1'b0;
      lane_last_write <= 1'b0;
      blur_addr_w     <= '0;
    end else begin
      blur_mem_we     <= rd_valid_q;
      lane_last_write <= rd_valid_q && rd_addr_q
                         == blur_types_pkg::row_addr_t'(blur_geom_pkg::IMG_ROWS - 1);
      if (ctrl.addr_clear) blur_addr_w <= '0;
      else if (rd_valid_q) blur_addr_w <= rd_addr_q;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_valid_q) blur_din <= merged;
  end

endmodule

`default_nettype wire

// File: pass_tracker.sv
`default_nettype none

module pass_tracker (
  input  logic                              clk,
  input  logic                              rst_n,
  lane_ctrl_if.tracker                      ctrl,
  input  logic [blur_geom_pkg::N_LANES-1:0] lane_last_write,
  output logic                              pass_end
);

  logic [blur_geom_pkg::N_LANES-1:0] lane_done;
  logic                              all_done;

  assign all_done = &lane_done;

  // Lanes finish at different steps, so hold each one until all are in
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lane_done <= '0;
      pass_end  <= 1'b0;
    end else begin
      pass_end <= all_done;
      if (ctrl.addr_clear || all_done) begin
        lane_done <= '0;
      end else begin
        lane_done <= lane_done | lane_last_write;
      end
    end
  end

endmodule

`default_nettype wire

// File: gaussian_blur_ctrl.sv
`default_nettype none

module gaussian_blur_ctrl (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              start,
  output logic                              done,
  output logic                              buffer_we,
  output logic                              fill_zero,
  output blur_types_pkg::row_addr_t         img_addr,
  output blur_types_pkg::col_idx_t          current_col,
  input  blur_types_pkg::seg_t              blur_result [blur_geom_pkg::N_LANES],
  input  blur_types_pkg::row_word_t         blur_dout   [blur_geom_pkg::N_LANES],
  output blur_types_pkg::row_word_t         blur_din    [blur_geom_pkg::N_LANES],
  output blur_types_pkg::row_addr_t         blur_addr_r [blur_geom_pkg::N_LANES],
  output blur_types_pkg::row_addr_t         blur_addr_w [blur_geom_pkg::N_LANES],
  output logic [blur_geom_pkg::N_LANES-1:0] blur_mem_we
);

  logic [blur_geom_pkg::N_LANES-1:0] lane_last_write;
  logic                              pass_end;

  lane_ctrl_if u_ctrl_if ();

  assign current_col = u_ctrl_if.current_col;

  blur_sequencer u_sequencer (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .pass_end  (pass_end),
    .ctrl      (u_ctrl_if),
    .img_addr  (img_addr),
    .buffer_we (buffer_we),
    .fill_zero (fill_zero),
    .done      (done)
  );

  for (genvar i = 0; i < blur_geom_pkg::N_LANES; i++) begin : g_lane
    blur_row_lane #(
      .START_STEP (blur_geom_pkg::LANE_START_STEP[i])
    ) u_lane (
      .clk             (clk),
      .rst_n           (rst_n),
      .ctrl            (u_ctrl_if),
      .blur_result     (blur_result[i]),
      .blur_dout       (blur_dout[i]),
      .blur_addr_r     (blur_addr_r[i]),
      .blur_addr_w     (blur_addr_w[i]),
      .blur_din        (blur_din[i]),
      .blur_mem_we     (blur_mem_we[i]),
      .lane_last_write (lane_last_write[i])
    );
  end

  pass_tracker u_pass_tracker (
    .clk             (clk),
    .rst_n           (rst_n),
    .ctrl            (u_ctrl_if),
    .lane_last_write (lane_last_write),
    .pass_end        (pass_end)
  );

endmodule

`default_nettype wire

// File: blur_ctrl_assert.sv
`default_nettype none

module blur_ctrl_assert (
  input logic                              clk,
  input logic                              rst_n,
  input logic                              done,
  input logic                              buffer_we,
  input logic                              fill_zero,
  input logic [blur_geom_pkg::N_LANES-1:0] blur_mem_we,
  input blur_types_pkg::row_addr_t         blur_addr_w [blur_geom_pkg::N_LANES]
);

  for (genvar i = 0; i < blur_geom_pkg::N_LANES; i++) begin : g_lane
    a_write_in_range: assert property (
      @(posedge clk) disable iff (!rst_n)
      blur_mem_we[i] |-> blur_addr_w[i] < blur_types_pkg::row_addr_t'(blur_geom_pkg::IMG_ROWS)
    ) else $error("lane %0d writes beyond the last row", i);
  end

  a_done_not_buffering: assert property (
    @(posedge clk) disable iff (!rst_n) !(done && buffer_we)
  ) else $error("done and buffer_we high in the same cycle");

  // Zero fill is a strobe
  a_fill_single: assert property (
    @(posedge clk) disable iff (!rst_n) fill_zero |=> !fill_zero
  ) else $error("fill_zero held for more than one cycle");

endmodule

bind gaussian_blur_ctrl blur_ctrl_assert u_blur_ctrl_assert (
  .clk         (clk),
  .rst_n       (rst_n),
  .done        (done),
  .buffer_we   (buffer_we),
  .fill_zero   (fill_zero),
  .blur_mem_we (blur_mem_we),
  .blur_addr_w (blur_addr_w)
);

`default_nettype wire

// File: tb_gaussian_blur_ctrl.sv
`default_nettype none

module tb_gaussian_blur_ctrl;

  localparam logic [31:0] SEED = 32'h4f73;
  localparam int DONE_TIMEOUT  = 500;
  localparam int CLEAR_TIMEOUT = 4;

  logic                                    clk;
  logic                                    rst_n;
  logic                                    start;
  logic                                    done;
  logic                                    buffer_we;
  logic                                    fill_zero;
  blur_types_pkg::row_addr_t               img_addr;
  blur_types_pkg::col_idx_t                current_col;
  blur_types_pkg::seg_t      blur_result [blur_geom_pkg::N_LANES] = '{default: '0};
  blur_types_pkg::row_word_t blur_dout   [blur_geom_pkg::N_LANES] = '{default: '0};
  blur_types_pkg::row_word_t blur_din    [blur_geom_pkg::N_LANES];
  blur_types_pkg::row_addr_t blur_addr_r [blur_geom_pkg::N_LANES];
  blur_types_pkg::row_addr_t blur_addr_w [blur_geom_pkg::N_LANES];
  logic [blur_geom_pkg::N_LANES-1:0]       blur_mem_we;

  // One spare row for the held end address
  blur_types_pkg::row_word_t mem [blur_geom_pkg::N_LANES][blur_geom_pkg::IMG_ROWS + 1];

  logic                      fill_req;
  logic [31:0]               fill_salt;
  int                        wr_cnt [blur_geom_pkg::N_LANES];
  blur_types_pkg::row_addr_t rd_hist1 [blur_geom_pkg::N_LANES];
  blur_types_pkg::row_addr_t rd_hist2 [blur_geom_pkg::N_LANES];
  blur_types_pkg::row_addr_t img_addr_prev;
  blur_types_pkg::row_addr_t img_addr_prev2;
  int                        bwe_cnt;
  int                        fill_cnt;

  gaussian_blur_ctrl u_gaussian_blur_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .done        (done),
    .buffer_we   (buffer_we),
    .fill_zero   (fill_zero),
    .img_addr    (img_addr),
    .current_col (current_col),
    .blur_result (blur_result),
    .blur_dout   (blur_dout),
    .blur_din    (blur_din),
    .blur_addr_r (blur_addr_r),
    .blur_addr_w (blur_addr_w),
    .blur_mem_we (blur_mem_we)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] x);
    return x * 32'd1664525 + 32'd1013904223;
  endfunction

  // Stand-in for the kernel output of one lane, column and row
  function automatic blur_types_pkg::seg_t exp_seg(input int lane, input int col, input int row);
    logic [31:0] v;
    v = lcg_next(SEED ^ (32'(lane) << 16) ^ (32'(col) << 8) ^ 32'(row));
    v = lcg_next(v);
    return blur_types_pkg::seg_t'(v >> 8);
  endfunction

  // Row after passes 0 up to col with column 0 in the top segment
  function automatic blur_types_pkg::row_word_t exp_row(input int lane, input int col,
                                                        input int row);
    blur_types_pkg::row_word_t w;
    w = '0;
    for (int c = 0; c < blur_geom_pkg::IMG_COLS; c++) begin
      w = w << blur_geom_pkg::SEG_W;
      if (c <= col) w = w | blur_types_pkg::row_word_t'(exp_seg(lane, c, row));
    end
    return w;
  endfunction

  function automatic blur_types_pkg::row_word_t garbage_word(input logic [31:0] salt,
                                                             input int lane, input int row);
    logic [31:0] v;
    v = lcg_next(SEED ^ salt ^ (32'(lane) << 8) ^ 32'(row));
    return blur_types_pkg::row_word_t'({lcg_next(v), v});
  endfunction

  task automatic abort_run();
    $display("Test failures found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_row(input string name, input blur_types_pkg::row_word_t exp,
                           input blur_types_pkg::row_word_t act);
    if (act !== exp) begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_addr(input string name, input blur_types_pkg::row_addr_t exp,
                            input blur_types_pkg::row_addr_t act);
    if (act !== exp) begin
      $display("** Error %s: expected %0d, actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_col(input string name, input blur_types_pkg::col_idx_t exp,
                           input blur_types_pkg::col_idx_t act);
    if (act !== exp) begin
      $display("** Error %s: expected %0d, actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error %s: expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("** Error %s: expected %0d, actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  // Blur SRAMs and kernel results trail the read address by one cycle
  always @(posedge clk) begin
    for (int i = 0; i < blur_geom_pkg::N_LANES; i++) begin
      if (fill_req) begin
        for (int r = 0; r <= blur_geom_pkg::IMG_ROWS; r++) begin
          mem[i][r] <= garbage_word(fill_salt, i, r);
        end
      end else if (blur_mem_we[i]) begin
        mem[i][blur_addr_w[i]] <= blur_din[i];
      end
      blur_dout[i]   <= mem[i][blur_addr_r[i]];
      blur_result[i] <= exp_seg(i, int'(current_col), int'(blur_addr_r[i]));
    end
  end

  always @(negedge clk) begin : compare
    int col;
    int row;
    if (start === 1'b1) begin
      for (int i = 0; i < blur_geom_pkg::N_LANES; i++) wr_cnt[i] = 0;
      bwe_cnt  = 0;
      fill_cnt = 0;
    end
    if (rst_n === 1'b1) begin
      for (int i = 0; i < blur_geom_pkg::N_LANES; i++) begin
        if (blur_mem_we[i]) begin
          col = wr_cnt[i] / blur_geom_pkg::IMG_ROWS;
          row = wr_cnt[i] % blur_geom_pkg::IMG_ROWS;
          check_addr($sformatf("lane %0d write row", i),
                     blur_types_pkg::row_addr_t'(row), blur_addr_w[i]);
          check_addr($sformatf("lane %0d read address two cycles before write", i),
                     blur_types_pkg::row_addr_t'(row), rd_hist2[i]);
          check_row($sformatf("lane %0d merged row %0d column %0d", i, row, col),
                    exp_row(i, col, row), blur_din[i]);
          wr_cnt[i]++;
        end
        rd_hist2[i] = rd_hist1[i];
        rd_hist1[i] = blur_addr_r[i];
      end
      if (buffer_we) bwe_cnt++;
      if (fill_zero) begin
        check_addr("img_addr in the cycle before fill_zero",
                   blur_types_pkg::row_addr_t'(blur_geom_pkg::IMG_ROWS), img_addr_prev);
        check_bit("img_addr below the end two cycles before fill_zero", 1'b1,
                  img_addr_prev2 < blur_types_pkg::row_addr_t'(blur_geom_pkg::IMG_ROWS));
        // Priming already steps img_addr, so the row phase covers only the rest
        check_count("buffer_we cycles in one pass",
                    2 + blur_geom_pkg::IMG_ROWS - blur_geom_pkg::PRIME_CYCLES, bwe_cnt);
        bwe_cnt = 0;
        fill_cnt++;
      end
      img_addr_prev2 = img_addr_prev;
      img_addr_prev  = img_addr;
    end
  end

  task automatic fill_garbage(input logic [31:0] salt);
    @(posedge clk);
    fill_salt <= salt;
    fill_req  <= 1'b1;
    @(posedge clk);
    fill_req  <= 1'b0;
  endtask

  task automatic run_blur();
    int cycles;
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    cycles = 0;
    while (done !== 1'b0 && cycles < CLEAR_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (done !== 1'b0) begin
      $display("Timeout: done stayed high after start");
      abort_run();
    end
    check_col("current_col after start", '0, current_col);
    cycles = 0;
    while (done !== 1'b1 && cycles < DONE_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (done !== 1'b1) begin
      $display("Timeout: done did not rise after start");
      abort_run();
    end
  endtask

  task automatic check_results(input string run);
    for (int i = 0; i < blur_geom_pkg::N_LANES; i++) begin
      check_count($sformatf("%s lane %0d writes", run, i),
                  blur_geom_pkg::IMG_ROWS * blur_geom_pkg::IMG_COLS, wr_cnt[i]);
      for (int r = 0; r < blur_geom_pkg::IMG_ROWS; r++) begin
        check_row($sformatf("%s final lane %0d row %0d", run, i, r),
                  exp_row(i, blur_geom_pkg::IMG_COLS - 1, r), mem[i][r]);
      end
    end
    check_count($sformatf("%s fill_zero pulses", run), blur_geom_pkg::IMG_COLS, fill_cnt);
  endtask

  initial begin
    rst_n    <= 1'b0;
    start    <= 1'b0;
    fill_req <= 1'b0;
    fill_salt <= '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_bit("done after reset", 1'b0, done);
    check_bit("buffer_we after reset", 1'b0, buffer_we);
    check_bit("fill_zero after reset", 1'b0, fill_zero);
    check_addr("img_addr after reset", '0, img_addr);
    for (int i = 0; i < blur_geom_pkg::N_LANES; i++) begin
      check_bit($sformatf("lane %0d write enable after reset", i), 1'b0, blur_mem_we[i]);
      check_addr($sformatf("lane %0d read address after reset", i), '0, blur_addr_r[i]);
      check_addr($sformatf("lane %0d write address after reset", i), '0, blur_addr_w[i]);
    end
    fill_garbage(32'h0000_1234);
    run_blur();
    check_results("first run");
    // Garbage above the current column must be overwritten with zeros
    fill_garbage(32'h5a5a_0000);
    run_blur();
    check_results("second run");
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
blur_geom_pkg.sv
blur_types_pkg.sv
lane_ctrl_if.sv
blur_sequencer.sv
blur_row_lane.sv
pass_tracker.sv
gaussian_blur_ctrl.sv
blur_ctrl_assert.sv
tb_gaussian_blur_ctrl.sv

// File: run.sh
#!/bin/sh
# Build and run the Gaussian blur control testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_gaussian_blur_ctrl \
  -f project.f \
  -o sim_tb

./obj_dir/sim_tb | tee sim.log

# The log decides the result
grep -q "All tests passed!" sim.log
echo "Simulation passed"
